// ==== Makefile ====
# Verilator flow for the UART peripheral
TOP = uart_tb

.PHONY: lint sim clean

lint:
	verilator --lint-only --timescale 1ns/100ps --top-module uart \
		hw/uart_pkg.sv hw/uart_tx.sv hw/uart_rx.sv hw/uart_rx_fifo.sv hw/uart.sv

sim:
	verilator --binary --timing --assert --timescale 1ns/100ps -f all.f \
		--top-module $(TOP) -o $(TOP)_sim
	./obj_dir/$(TOP)_sim | tee sim.log
	grep -q '^\*\* PASS \*\*$$' sim.log

clean:
	rm -rf obj_dir sim.log

// ==== all.f ====
hw/uart_pkg.sv
hw/uart_tx.sv
hw/uart_rx.sv
hw/uart_rx_fifo.sv
hw/uart.sv
verification/uart_tb.sv

// ==== hw/uart.sv ====
// Memory-mapped UART peripheral
// Bus request decode, configuration and status registers,
// registered bus response and interrupt, transmitter, receiver and FIFO
`timescale 1ns/100ps

module uart import uart_pkg::*; (
    input  logic            clk,
    input  logic            rst_n,
    input  logic [5:0]      addr_i,
    input  logic            req_i,
    input  logic            w_en_i,
    input  logic            sel_i,
    input  logic [XLEN-1:0] w_data_i,
    output logic [XLEN-1:0] r_data_o,
    output logic            ack_o,
    output logic            irq_o,
    input  logic            rxd_i,
    output logic            txd_o
);

    type_uart_regs_e               reg_idx;
    logic                          accept;
    logic                          rd_req;
    logic                          wr_req;
    logic [XLEN-1:0]               rd_data;

    logic [UART_BAUD_DIV_SIZE-1:0] baud_q;
    logic                          two_stop_q;
    logic [UART_STATUS_SIZE-1:0]   int_mask_q;
    logic [UART_DATA_SIZE-1:0]     tx_byte_q;
    logic                          tx_valid_q;
    logic                          frame_err_q;
    logic [UART_STATUS_SIZE-1:0]   status;

    logic                          ack_q;
    logic [XLEN-1:0]               r_data_q;
    logic                          irq_q;

    logic                          tx_ready;
    logic [UART_DATA_SIZE-1:0]     rx_byte;
    logic                          rx_valid;
    logic                          rx_frame_err;
    logic                          fifo_pop;
    logic [UART_DATA_SIZE-1:0]     fifo_rd_data;
    logic                          fifo_empty;

    // --------------------------------------------------
    // Bus decode
    // --------------------------------------------------
    // A request held through its own ack cycle is not taken again
    assign reg_idx = type_uart_regs_e'(addr_i[5:2]);
    assign accept  = req_i & sel_i & ~ack_q;
    assign rd_req  = accept & ~w_en_i;
    assign wr_req  = accept & w_en_i;

    assign fifo_pop = rd_req & (reg_idx == UART_RXDATA_R) & ~fifo_empty;

    always_comb begin
        status                   = '0;
        status[STATUS_TX_READY]  = tx_ready;
        status[STATUS_RX_AVAIL]  = ~fifo_empty;
        status[STATUS_FRAME_ERR] = frame_err_q;
    end

    always_comb begin
        rd_data = '0;
        case (reg_idx)
            UART_TXDATA_R: begin
                rd_data[TXDATA_BUSY_BIT] = ~tx_ready;
            end
            UART_RXDATA_R: begin
                rd_data[RXDATA_EMPTY_BIT] = fifo_empty;
                if (!fifo_empty) begin
                    rd_data[UART_DATA_SIZE-1:0] = fifo_rd_data;
                end
            end
            UART_TXCTRL_R:   rd_data[TXCTRL_TWO_STOP_BIT] = two_stop_q;
            UART_STATUS_R:   rd_data[UART_STATUS_SIZE-1:0] = status;
            UART_BAUD_R:     rd_data[UART_BAUD_DIV_SIZE-1:0] = baud_q;
            UART_INT_MASK_R: rd_data[UART_STATUS_SIZE-1:0] = int_mask_q;
            // RXCTRL and the reserved index read zero
            default:         rd_data = '0;
        endcase
    end

    // --------------------------------------------------
    // Register file
    // --------------------------------------------------
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            baud_q      <= UART_BAUD_RESET;
            two_stop_q  <= 1'b0;
            int_mask_q  <= '0;
            tx_byte_q   <= '0;
            tx_valid_q  <= 1'b0;
            frame_err_q <= 1'b0;
        end else begin
            tx_valid_q <= 1'b0;
            if (wr_req) begin
                case (reg_idx)
                    UART_TXDATA_R: begin
                        // Writes while a frame is in flight are lost
                        if (tx_ready) begin
                            tx_byte_q  <= w_data_i[UART_DATA_SIZE-1:0];
                            tx_valid_q <= 1'b1;
                        end
                    end
                    UART_TXCTRL_R:   two_stop_q <= w_data_i[TXCTRL_TWO_STOP_BIT];
                    UART_BAUD_R:     baud_q     <= w_data_i[UART_BAUD_DIV_SIZE-1:0];
                    UART_INT_MASK_R: int_mask_q <= w_data_i[UART_STATUS_SIZE-1:0];
                    default: begin
                    end
                endcase
            end
            // Sticky until a STATUS read, unless a new error arrives with it
            if (rx_frame_err) begin
                frame_err_q <= 1'b1;
            end else if (rd_req && reg_idx == UART_STATUS_R) begin
                frame_err_q <= 1'b0;
            end
        end
    end

    // --------------------------------------------------
    // Bus response and interrupt
    // --------------------------------------------------
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            ack_q <= 1'b0;
            irq_q <= 1'b0;
        end else begin
            ack_q <= accept;
            irq_q <= |(status & int_mask_q);
        end
    end

    // Zero unless a read is answered
    always_ff @(posedge clk) begin
        r_data_q <= rd_req ? rd_data : '0;
    end

    assign ack_o    = ack_q;
    assign r_data_o = r_data_q;
    assign irq_o    = irq_q;

    // --------------------------------------------------
    // Serial side
    // --------------------------------------------------
    uart_tx u_tx (
        .clk             (clk),
        .rst_n           (rst_n),
        .data_i          (tx_byte_q),
        .valid_i         (tx_valid_q),
        .two_stop_bits_i (two_stop_q),
        .baud_div_i      (baud_q),
        .txd_o           (txd_o),
        .ready_o         (tx_ready)
    );

    uart_rx u_rx (
        .clk         (clk),
        .rst_n       (rst_n),
        .rxd_i       (rxd_i),
        .baud_div_i  (baud_q),
        .data_o      (rx_byte),
        .valid_o     (rx_valid),
        .frame_err_o (rx_frame_err)
    );

    uart_rx_fifo u_rx_fifo (
        .clk       (clk),
        .rst_n     (rst_n),
        .push_i    (rx_valid),
        .data_i    (rx_byte),
        .pop_i     (fifo_pop),
        .rd_data_o (fifo_rd_data),
        .empty_o   (fifo_empty),
        .full_o    ()
    );

endmodule

// ==== hw/uart_pkg.sv ====
// Shared constants for the UART peripheral
// Bus and character widths, FIFO depth, register word indexes,
// register field positions and reset values
package uart_pkg;

    // Widths
    localparam int XLEN               = 32;
    localparam int UART_DATA_SIZE     = 8;
    localparam int UART_BAUD_DIV_SIZE = 16;
    localparam int UART_BIT_CNT_SIZE  = $clog2(UART_DATA_SIZE);

    // Receive FIFO geometry
    localparam int UART_FIFO_DEPTH    = 8;
    localparam int UART_FIFO_PTR_SIZE = $clog2(UART_FIFO_DEPTH);

    // Register word indexes, taken from address bits 5..2
    typedef enum logic [3:0] {
        UART_TXDATA_R   = 4'd0,
        UART_RXDATA_R   = 4'd1,
        UART_TXCTRL_R   = 4'd2,
        UART_RXCTRL_R   = 4'd3,
        UART_STATUS_R   = 4'd4,
        UART_BAUD_R     = 4'd6,
        UART_INT_MASK_R = 4'd7
    } type_uart_regs_e;

    // STATUS fields, INT_MASK uses the same layout
    localparam int UART_STATUS_SIZE = 3;
    localparam int STATUS_TX_READY  = 0;
    localparam int STATUS_RX_AVAIL  = 1;
    localparam int STATUS_FRAME_ERR = 2;

    // Other register fields
    localparam int TXDATA_BUSY_BIT      = XLEN - 1;
    localparam int RXDATA_EMPTY_BIT     = XLEN - 1;
    localparam int TXCTRL_TWO_STOP_BIT  = 0;

    // Divisor after reset, in clocks per bit
    localparam logic [UART_BAUD_DIV_SIZE-1:0] UART_BAUD_RESET = 16'd16;

endpackage

// ==== hw/uart_rx.sv ====
// UART serial receiver
// Two-flop input synchronizer, start edge detection, mid-bit sampling
// and stop bit check with one-cycle result pulses
`timescale 1ns/100ps

module uart_rx import uart_pkg::*; (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic                          rxd_i,
    input  logic [UART_BAUD_DIV_SIZE-1:0] baud_div_i,
    output logic [UART_DATA_SIZE-1:0]     data_o,
    output logic                          valid_o,
    output logic                          frame_err_o
);

    typedef enum logic [1:0] {
        RX_IDLE,
        RX_START,
        RX_DATA,
        RX_STOP
    } rx_state_e;

    rx_state_e                     state_q;
    logic                          rxd_meta_q;
    logic                          rxd_sync_q;
    logic                          rxd_prev_q;
    logic                          fall_edge;
    logic                          sample;
    logic [UART_BAUD_DIV_SIZE-1:0] baud_cnt_q;
    logic [UART_BIT_CNT_SIZE-1:0]  bit_cnt_q;
    logic [UART_DATA_SIZE-1:0]     shift_q;
    logic                          valid_q;
    logic                          frame_err_q;

    // --------------------------------------------------
    // Input synchronizer and edge detector
    // --------------------------------------------------
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            rxd_meta_q <= 1'b1;
            rxd_sync_q <= 1'b1;
            rxd_prev_q <= 1'b1;
        end else begin
            rxd_meta_q <= rxd_i;
            rxd_sync_q <= rxd_meta_q;
            rxd_prev_q <= rxd_sync_q;
        end
    end

    assign fall_edge = rxd_prev_q & ~rxd_sync_q;
    assign sample    = (baud_cnt_q == '0);

    // --------------------------------------------------
    // Frame state machine
    // --------------------------------------------------
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state_q     <= RX_IDLE;
            baud_cnt_q  <= '0;
            bit_cnt_q   <= '0;
            valid_q     <= 1'b0;
            frame_err_q <= 1'b0;
        end else begin
            valid_q     <= 1'b0;
            frame_err_q <= 1'b0;
            baud_cnt_q  <= sample ? baud_div_i - 1'b1 : baud_cnt_q - 1'b1;
            case (state_q)
                RX_IDLE: begin
                    // First sample lands half a bit after the edge
                    baud_cnt_q <= baud_div_i >> 1;
                    if (fall_edge) begin
                        state_q <= RX_START;
                    end
                end
                RX_START: begin
                    if (sample) begin
                        bit_cnt_q <= '0;
                        // A high start sample is treated as a glitch
                        state_q   <= rxd_sync_q ? RX_IDLE : RX_DATA;
                    end
                end
                RX_DATA: begin
                    if (sample) begin
                        bit_cnt_q <= bit_cnt_q + 1'b1;
                        if (bit_cnt_q == UART_BIT_CNT_SIZE'(UART_DATA_SIZE - 1)) begin
                            state_q <= RX_STOP;
                        end
                    end
                end
                RX_STOP: begin
                    if (sample) begin
                        valid_q     <= rxd_sync_q;
                        frame_err_q <= ~rxd_sync_q;
                        state_q     <= RX_IDLE;
                    end
                end
                default: state_q <= RX_IDLE;
            endcase
        end
    end

    // Data bits arrive LSB first
    always_ff @(posedge clk) begin
        if (state_q == RX_DATA && sample) begin
            shift_q <= {rxd_sync_q, shift_q[UART_DATA_SIZE-1:1]};
        end
    end

    assign data_o      = shift_q;
    assign valid_o     = valid_q;
    assign frame_err_o = frame_err_q;

endmodule

// ==== hw/uart_rx_fifo.sv ====
// Receive byte FIFO
// Circular buffer with read and write pointers, an entry count,
// and full and empty flags
`timescale 1ns/100ps

module uart_rx_fifo import uart_pkg::*; (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      push_i,
    input  logic [UART_DATA_SIZE-1:0] data_i,
    input  logic                      pop_i,
    output logic [UART_DATA_SIZE-1:0] rd_data_o,
    output logic                      empty_o,
    output logic                      full_o
);

    logic [UART_DATA_SIZE-1:0]     mem [UART_FIFO_DEPTH];
    logic [UART_FIFO_PTR_SIZE-1:0] wr_ptr_q;
    logic [UART_FIFO_PTR_SIZE-1:0] rd_ptr_q;
    logic [UART_FIFO_PTR_SIZE:0]   count_q;
    logic                          do_push;
    logic                          do_pop;

    assign empty_o = (count_q == '0);
    assign full_o  = (count_q == (UART_FIFO_PTR_SIZE + 1)'(UART_FIFO_DEPTH));

    // A pop frees a slot in the same cycle, so a push alongside it is kept
    assign do_pop  = pop_i & ~empty_o;
    assign do_push = push_i & (~full_o | do_pop);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr_q <= wr_ptr_q + 1'b1;
            end
            if (do_pop) begin
                rd_ptr_q <= rd_ptr_q + 1'b1;
            end
            if (do_push && !do_pop) begin
                count_q <= count_q + 1'b1;
            end else if (do_pop && !do_push) begin
                count_q <= count_q - 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (do_push) begin
            mem[wr_ptr_q] <= data_i;
        end
    end

    assign rd_data_o = mem[rd_ptr_q];

endmodule

// ==== hw/uart_tx.sv ====
// UART serial transmitter
// Start bit, eight data bits LSB first, one or two stop bits,
// each bit held for baud_div_i clocks
`timescale 1ns/100ps

module uart_tx import uart_pkg::*; (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic [UART_DATA_SIZE-1:0]     data_i,
    input  logic                          valid_i,
    input  logic                          two_stop_bits_i,
    input  logic [UART_BAUD_DIV_SIZE-1:0] baud_div_i,
    output logic                          txd_o,
    output logic                          ready_o
);

    typedef enum logic [2:0] {
        TX_IDLE,
        TX_START,
        TX_DATA,
        TX_STOP1,
        TX_STOP2
    } tx_state_e;

    tx_state_e                     state_q;
    logic [UART_BAUD_DIV_SIZE-1:0] baud_cnt_q;
    logic [UART_BIT_CNT_SIZE-1:0]  bit_cnt_q;
    logic [UART_DATA_SIZE-1:0]     shift_q;
    logic                          two_stop_q;
    logic                          txd_q;
    logic                          bit_done;

    assign bit_done = (baud_cnt_q == '0);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state_q    <= TX_IDLE;
            baud_cnt_q <= '0;
            bit_cnt_q  <= '0;
            two_stop_q <= 1'b0;
            txd_q      <= 1'b1;
        end else begin
            baud_cnt_q <= bit_done ? baud_div_i - 1'b1 : baud_cnt_q - 1'b1;
            case (state_q)
                TX_IDLE: begin
                    txd_q      <= 1'b1;
                    baud_cnt_q <= baud_div_i - 1'b1;
                    if (valid_i) begin
                        two_stop_q <= two_stop_bits_i;
                        txd_q      <= 1'b0;
                        state_q    <= TX_START;
                    end
                end
                TX_START: begin
                    if (bit_done) begin
                        txd_q     <= shift_q[0];
                        bit_cnt_q <= '0;
                        state_q   <= TX_DATA;
                    end
                end
                TX_DATA: begin
                    if (bit_done) begin
                        if (bit_cnt_q == UART_BIT_CNT_SIZE'(UART_DATA_SIZE - 1)) begin
                            txd_q   <= 1'b1;
                            state_q <= TX_STOP1;
                        end else begin
                            txd_q     <= shift_q[1];
                            bit_cnt_q <= bit_cnt_q + 1'b1;
                        end
                    end
                end
                TX_STOP1: begin
                    if (bit_done) begin
                        state_q <= two_stop_q ? TX_STOP2 : TX_IDLE;
                    end
                end
                TX_STOP2: begin
                    if (bit_done) begin
                        state_q <= TX_IDLE;
                    end
                end
                default: state_q <= TX_IDLE;
            endcase
        end
    end

    // Character shifter, loaded when a frame starts
    always_ff @(posedge clk) begin
        if (state_q == TX_IDLE && valid_i) begin
            shift_q <= data_i;
        end else if (state_q == TX_DATA && bit_done) begin
            shift_q <= shift_q >> 1;
        end
    end

    assign txd_o   = txd_q;
    assign ready_o = (state_q == TX_IDLE);

endmodule

// ==== verification/uart_tb.sv ====
// UART peripheral testbench
// Clock and reset, bus read and write tasks, serial driver and txd_o monitor,
// self-checking tests with per-test results and closing counts
`timescale 1ns/100ps

module uart_tb import uart_pkg::*; ();

    localparam int          CLK_HALF       = 20;
    localparam int          TIMEOUT_CYCLES = 20000;
    localparam int          BUS_TIMEOUT    = 8;
    localparam int          POLL_LIMIT     = 200;
    localparam int          TX_DIV         = 8;
    localparam int          RX_DIV         = 16;
    localparam int          RX_BURST       = 5;
    localparam int          OVERFLOW_BURST = 10;
    localparam int          FIFO_ENTRIES   = 8;
    localparam logic [31:0] BAUD_AFTER_RST = 32'd16;
    localparam logic [31:0] TOP_BIT_WORD   = 32'h8000_0000;

    logic        clk = 1'b0;
    logic        rst_n;
    logic [5:0]  addr_i;
    logic        req_i;
    logic        w_en_i;
    logic        sel_i;
    logic [31:0] w_data_i;
    logic [31:0] r_data_o;
    logic        ack_o;
    logic        irq_o;
    logic        rxd_i;
    logic        txd_o;

    int          seed = 93980;
    int          cycle_cnt = 0;
    int          errors = 0;
    int          test_start_errors = 0;
    int          tests_passed = 0;
    int          tests_failed = 0;
    string       cur_test = "startup";
    logic        irq_quiet;

    uart dut0 (
        .clk      (clk),
        .rst_n    (rst_n),
        .addr_i   (addr_i),
        .req_i    (req_i),
        .w_en_i   (w_en_i),
        .sel_i    (sel_i),
        .w_data_i (w_data_i),
        .r_data_o (r_data_o),
        .ack_o    (ack_o),
        .irq_o    (irq_o),
        .rxd_i    (rxd_i),
        .txd_o    (txd_o)
    );

    always #(CLK_HALF) clk = ~clk;

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
    end

    // --------------------------------------------------
    // Bus protocol properties
    // --------------------------------------------------
    ack_follows_req: assert property (@(posedge clk) disable iff (!rst_n)
        (req_i && sel_i && !ack_o) |=> ack_o)
    else begin
        $display("%s: ack_o did not follow an accepted request", cur_test);
        errors++;
    end

    ack_single: assert property (@(posedge clk) disable iff (!rst_n) ack_o |=> !ack_o)
    else begin
        $display("%s: ack_o stayed high for more than one cycle", cur_test);
        errors++;
    end

    irq_held_low: assert property (@(posedge clk) disable iff (!rst_n) irq_quiet |-> !irq_o)
    else begin
        $display("%s: irq_o rose while every interrupt source was masked", cur_test);
        errors++;
    end

    // --------------------------------------------------
    // Checking and bookkeeping
    // --------------------------------------------------
    task automatic check_eq(input string what, input logic [31:0] exp, input logic [31:0] act);
        assert (act === exp)
        else begin
            $display("[ERROR] %s: %s expected 0x%08h actual 0x%08h", cur_test, what, exp, act);
            errors++;
        end
    endtask

    task automatic begin_test(input string name);
        cur_test = name;
        test_start_errors = errors;
    endtask

    task automatic end_test();
        if (errors == test_start_errors) begin
            tests_passed++;
            $display("test %s: passed", cur_test);
        end else begin
            tests_failed++;
            $display("test %s: failed with %0d errors", cur_test, errors - test_start_errors);
        end
    endtask

    function automatic logic [31:0] status_word(input logic tx_ready, input logic rx_avail,
                                                input logic frame_err);
        logic [31:0] w;
        w = '0;
        w[STATUS_TX_READY]  = tx_ready;
        w[STATUS_RX_AVAIL]  = rx_avail;
        w[STATUS_FRAME_ERR] = frame_err;
        return w;
    endfunction

    // --------------------------------------------------
    // Bus master
    // --------------------------------------------------
    task automatic bus_access(input logic [3:0] idx, input logic write,
                              input logic [31:0] wdata, output logic [31:0] rdata);
        int waited;
        waited = 0;
        @(negedge clk);
        addr_i   = {idx, 2'b00};
        w_en_i   = write;
        w_data_i = wdata;
        req_i    = 1'b1;
        sel_i    = 1'b1;
        do begin
            @(negedge clk);
            waited++;
        end while (!ack_o && waited < BUS_TIMEOUT);
        if (!ack_o) begin
            $display("%s: no ack for a transfer to register %0d", cur_test, idx);
            errors++;
        end
        check_eq("ack latency", 32'd1, 32'(waited));
        rdata  = r_data_o;
        req_i  = 1'b0;
        sel_i  = 1'b0;
        w_en_i = 1'b0;
    endtask

    task automatic reg_write(input logic [3:0] idx, input logic [31:0] wdata);
        logic [31:0] rdata;
        bus_access(idx, 1'b1, wdata, rdata);
        check_eq("read data during write", 32'd0, rdata);
    endtask

    task automatic reg_read(input logic [3:0] idx, output logic [31:0] rdata);
        bus_access(idx, 1'b0, 32'd0, rdata);
    endtask

    task automatic wait_rx_avail();
        logic [31:0] rd;
        int          polls;
        polls = 0;
        rd    = '0;
        while (!rd[STATUS_RX_AVAIL] && polls < POLL_LIMIT) begin
            reg_read(UART_STATUS_R, rd);
            polls++;
        end
        if (!rd[STATUS_RX_AVAIL]) begin
            $display("%s: received data never showed up in STATUS", cur_test);
            errors++;
        end
    endtask

    task automatic wait_irq(input logic level);
        int waited;
        waited = 0;
        while (irq_o !== level && waited < POLL_LIMIT) begin
            @(negedge clk);
            waited++;
        end
        if (irq_o !== level) begin
            $display("%s: irq_o did not go to %0b in %0d cycles", cur_test, level, POLL_LIMIT);
            errors++;
        end
    endtask

    // --------------------------------------------------
    // Serial line models
    // --------------------------------------------------
    // One frame on rxd_i followed by one idle bit time
    task automatic send_serial(input logic [7:0] data, input int div, input logic stop_val);
        @(negedge clk);
        rxd_i = 1'b0;
        repeat (div) @(negedge clk);
        for (int i = 0; i < 8; i++) begin
            rxd_i = data[i];
            repeat (div) @(negedge clk);
        end
        rxd_i = stop_val;
        repeat (div) @(negedge clk);
        rxd_i = 1'b1;
        repeat (div) @(negedge clk);
    endtask

    // Samples txd_o at mid-bit, counted from the start bit's falling edge
    task automatic watch_tx_frame(input int div, input int two_stop, output logic [7:0] data);
        int waited;
        waited = 0;
        data   = '0;
        @(negedge clk);
        while (txd_o !== 1'b0 && waited < POLL_LIMIT) begin
            @(negedge clk);
            waited++;
        end
        if (txd_o !== 1'b0) begin
            $display("%s: no start bit appeared on txd_o", cur_test);
            errors++;
        end else begin
            repeat (div / 2) @(negedge clk);
            check_eq("start bit", 32'd0, 32'(txd_o));
            for (int i = 0; i < 8; i++) begin
                repeat (div) @(negedge clk);
                data[i] = txd_o;
            end
            repeat (div) @(negedge clk);
            check_eq("first stop bit", 32'd1, 32'(txd_o));
            if (two_stop != 0) begin
                repeat (div) @(negedge clk);
                check_eq("second stop bit", 32'd1, 32'(txd_o));
            end
        end
    endtask

    // --------------------------------------------------
    // Tests
    // --------------------------------------------------
    task automatic reset_and_access();
        logic [31:0] rd;
        logic [31:0] wr;
        begin_test("reset_regs");
        check_eq("ack_o after reset", 32'd0, 32'(ack_o));
        check_eq("irq_o after reset", 32'd0, 32'(irq_o));
        check_eq("txd_o after reset", 32'd1, 32'(txd_o));
        reg_read(UART_BAUD_R, rd);
        check_eq("BAUD", BAUD_AFTER_RST, rd);
        reg_read(UART_TXCTRL_R, rd);
        check_eq("TXCTRL", 32'd0, rd);
        reg_read(UART_INT_MASK_R, rd);
        check_eq("INT_MASK", 32'd0, rd);
        reg_read(UART_STATUS_R, rd);
        check_eq("STATUS", status_word(1'b1, 1'b0, 1'b0), rd);
        reg_read(UART_RXDATA_R, rd);
        check_eq("RXDATA", TOP_BIT_WORD, rd);
        reg_read(UART_TXDATA_R, rd);
        check_eq("TXDATA", 32'd0, rd);
        reg_read(UART_RXCTRL_R, rd);
        check_eq("RXCTRL", 32'd0, rd);
        reg_read(4'd5, rd);
        check_eq("reserved register", 32'd0, rd);
        wr = $random(seed);
        reg_write(UART_BAUD_R, wr);
        reg_read(UART_BAUD_R, rd);
        check_eq("BAUD readback", wr & 32'h0000_ffff, rd);
        wr = $random(seed);
        reg_write(UART_TXCTRL_R, wr);
        reg_read(UART_TXCTRL_R, rd);
        check_eq("TXCTRL readback", wr & 32'h0000_0001, rd);
        wr = $random(seed);
        reg_write(UART_INT_MASK_R, wr);
        reg_read(UART_INT_MASK_R, rd);
        check_eq("INT_MASK readback", wr & 32'h0000_0007, rd);
        reg_write(UART_BAUD_R, BAUD_AFTER_RST);
        reg_write(UART_TXCTRL_R, 32'd0);
        reg_write(UART_INT_MASK_R, 32'd0);
        end_test();
    endtask

    task automatic transmit_frames();
        logic [7:0]  tx_byte;
        logic [7:0]  got;
        logic [31:0] rd;
        begin_test("tx_frame");
        reg_write(UART_BAUD_R, 32'(TX_DIV));
        for (int stops = 0; stops < 2; stops++) begin
            reg_write(UART_TXCTRL_R, 32'(stops));
            repeat (2) begin
                tx_byte = 8'($random(seed));
                fork
                    watch_tx_frame(TX_DIV, stops, got);
                    begin
                        reg_write(UART_TXDATA_R, {24'd0, tx_byte});
                        reg_read(UART_TXDATA_R, rd);
                        check_eq("TXDATA busy in frame", TOP_BIT_WORD, rd);
                    end
                join
                check_eq("decoded byte", {24'd0, tx_byte}, {24'd0, got});
                // Half of the last stop bit is still on the line
                reg_read(UART_TXDATA_R, rd);
                check_eq("TXDATA busy in last stop bit", TOP_BIT_WORD, rd);
                // This read lands half a bit after the last stop bit ends
                repeat (TX_DIV / 2) @(negedge clk);
                reg_read(UART_TXDATA_R, rd);
                check_eq("TXDATA idle after frame", 32'd0, rd);
            end
        end
        reg_write(UART_TXCTRL_R, 32'd0);
        reg_write(UART_BAUD_R, 32'(RX_DIV));
        end_test();
    endtask

    task automatic receive_bytes(input string name, input int count, input int kept);
        logic [7:0]  sent [OVERFLOW_BURST];
        logic [31:0] rd;
        begin_test(name);
        for (int i = 0; i < count; i++) begin
            sent[i] = 8'($random(seed));
            send_serial(sent[i], RX_DIV, 1'b1);
        end
        wait_rx_avail();
        for (int i = 0; i < kept; i++) begin
            reg_read(UART_RXDATA_R, rd);
            check_eq("RXDATA byte", {24'd0, sent[i]}, rd);
        end
        reg_read(UART_RXDATA_R, rd);
        check_eq("RXDATA after drain", TOP_BIT_WORD, rd);
        end_test();
    endtask

    task automatic frame_error_flag();
        logic [31:0] rd;
        begin_test("frame_error");
        send_serial(8'($random(seed)), RX_DIV, 1'b0);
        reg_read(UART_STATUS_R, rd);
        check_eq("STATUS with frame error", status_word(1'b1, 1'b0, 1'b1), rd);
        reg_read(UART_STATUS_R, rd);
        check_eq("STATUS after clear", status_word(1'b1, 1'b0, 1'b0), rd);
        reg_read(UART_RXDATA_R, rd);
        check_eq("RXDATA after bad frame", TOP_BIT_WORD, rd);
        end_test();
    endtask

    task automatic interrupt_mask();
        logic [7:0]  rx_byte;
        logic [31:0] rd;
        begin_test("interrupt");
        irq_quiet = 1'b1;
        rx_byte   = 8'($random(seed));
        send_serial(rx_byte, RX_DIV, 1'b1);
        wait_rx_avail();
        repeat (4) @(negedge clk);
        irq_quiet = 1'b0;
        reg_write(UART_INT_MASK_R, status_word(1'b0, 1'b1, 1'b0));
        wait_irq(1'b1);
        reg_read(UART_RXDATA_R, rd);
        check_eq("RXDATA byte", {24'd0, rx_byte}, rd);
        wait_irq(1'b0);
        reg_write(UART_INT_MASK_R, 32'd0);
        end_test();
    endtask

    // --------------------------------------------------
    // Run control
    // --------------------------------------------------
    initial begin
        rst_n     = 1'b0;
        addr_i    = '0;
        req_i     = 1'b0;
        w_en_i    = 1'b0;
        sel_i     = 1'b0;
        w_data_i  = '0;
        rxd_i     = 1'b1;
        irq_quiet = 1'b0;
        repeat (2) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;

        reset_and_access();
        transmit_frames();
        receive_bytes("rx_order", RX_BURST, RX_BURST);
        receive_bytes("fifo_overflow", OVERFLOW_BURST, FIFO_ENTRIES);
        frame_error_flag();
        interrupt_mask();

        $display("tests passed %0d failed %0d, errors %0d", tests_passed, tests_failed, errors);
        if (tests_failed == 0 && errors == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

    initial begin
        wait (cycle_cnt >= TIMEOUT_CYCLES);
        $display("timeout: run stopped after %0d cycles in test %s", cycle_cnt, cur_test);
        $display("** FAIL **");
        $finish;
    end

endmodule
